/* mul_defines.svh */
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

// operand width at the multiplier ports
`define MUL_WIDTH 32

// operand plus one sign or zero bit
`define MUL_EXT_WIDTH 33

// radix-4 digits, one partial product each
`define MUL_DIGITS 17

// partial product and tree row width
`define MUL_ROW_WIDTH 65

// padded recoding source, a zero below bit 0 and a copied top bit
`define MUL_PAD_WIDTH 35

`endif

/* mul_types_pkg.sv */
`include "mul_defines.svh"

package mul_types_pkg;

  // operand interpretation, matches the mul_signed pin
  typedef enum logic {
    MODE_UNSIGNED = 1'b0,
    MODE_SIGNED   = 1'b1
  } mul_mode_e;

  // one multiplier operand
  typedef logic [`MUL_WIDTH-1:0] operand_t;

  // full-width product, signed view
  typedef logic signed [2*`MUL_WIDTH-1:0] product_t;

endpackage

/* booth_pkg.sv */
`include "mul_defines.svh"

package booth_pkg;

  // selection made by one radix-4 digit
  typedef enum logic [2:0] {
    DIGIT_ZERO = 3'b000,
    DIGIT_POS1 = 3'b001,
    DIGIT_POS2 = 3'b010,
    DIGIT_NEG2 = 3'b110,
    DIGIT_NEG1 = 3'b111
  } booth_digit_e;

  // one partial product or tree row
  typedef logic signed [`MUL_ROW_WIDTH-1:0] row_t;

  // all partial products, index i is weighted by 4**i
  typedef row_t [`MUL_DIGITS-1:0] pp_array_t;

  // rows crossing the pipeline register
  typedef struct packed {
    row_t sum_a;
    row_t sum_b;
    row_t carry_a;
    row_t carry_b;
  } csa_rows_t;

  // output of one carry-save step
  typedef struct packed {
    row_t sum;
    row_t carry;
  } csa_pair_t;

  // 3:2 compression of whole rows, carry moves up one bit
  function automatic csa_pair_t csa3(input row_t x, input row_t y, input row_t z);
    csa_pair_t r;
    r.sum   = x ^ y ^ z;
    r.carry = ((x & y) | (x & z) | (y & z)) << 1;
    return r;
  endfunction

endpackage

/* booth_pp_gen.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module booth_pp_gen (
  input  logic                     clk,
  input  logic                     resetn,
  input  mul_types_pkg::mul_mode_e mul_signed,
  input  mul_types_pkg::operand_t  ina,
  input  mul_types_pkg::operand_t  inb,
  output booth_pkg::pp_array_t     partial_products
);
  import mul_types_pkg::*;
  import booth_pkg::*;

  // registered request, first pipeline stage
  typedef struct packed {
    mul_mode_e mode;
    operand_t  a;
    operand_t  b;
  } mul_req_t;

  mul_req_t                         req_q;
  logic signed [`MUL_EXT_WIDTH-1:0] ext_ina;
  logic signed [`MUL_EXT_WIDTH-1:0] ext_inb;
  logic [`MUL_PAD_WIDTH-1:0]        a_pad;
  row_t                             b_row;
  booth_digit_e [`MUL_DIGITS-1:0]   digits;

  // radix-4 recoding of one overlapping triple
  function automatic booth_digit_e recode(input logic [2:0] t);
    booth_digit_e d;
    case (t)
      3'b001, 3'b010: d = DIGIT_POS1;
      3'b011:         d = DIGIT_POS2;
      3'b100:         d = DIGIT_NEG2;
      3'b101, 3'b110: d = DIGIT_NEG1;
      default:        d = DIGIT_ZERO;
    endcase
    return d;
  endfunction

  // multiple of b picked by a digit, before its shift
  function automatic row_t select_multiple(input booth_digit_e d, input row_t b);
    row_t m;
    case (d)
      DIGIT_POS1: m = b;
      DIGIT_POS2: m = b <<< 1;
      DIGIT_NEG2: m = -(b <<< 1);
      DIGIT_NEG1: m = -b;
      default:    m = '0;
    endcase
    return m;
  endfunction

  always_ff @(posedge clk) begin
    if (!resetn) begin
      req_q <= '0;
    end else begin
      req_q <= '{mode: mul_signed, a: ina, b: inb};
    end
  end

  // one extra bit, sign in signed mode and zero otherwise
  assign ext_ina = {(req_q.mode == MODE_SIGNED) && req_q.a[`MUL_WIDTH-1], req_q.a};
  assign ext_inb = {(req_q.mode == MODE_SIGNED) && req_q.b[`MUL_WIDTH-1], req_q.b};

  // top bit copied once more so the last triple stays in range
  assign a_pad = {ext_ina[`MUL_EXT_WIDTH-1], ext_ina, 1'b0};
  assign b_row = {{(`MUL_ROW_WIDTH-`MUL_EXT_WIDTH){ext_inb[`MUL_EXT_WIDTH-1]}}, ext_inb};

  for (genvar i = 0; i < `MUL_DIGITS; i++) begin : g_digit
    assign digits[i]           = recode(a_pad[2*i+2 -: 3]);
    assign partial_products[i] = select_multiple(digits[i], b_row) << (2*i);
  end

  // top triple is bit 32 twice plus bit 31, so never a double
  a_top_digit_single : assert property (
    @(posedge clk) disable iff (!resetn)
    resetn |=> !(digits[`MUL_DIGITS-1] inside {DIGIT_POS2, DIGIT_NEG2})
  );

endmodule

/* wallace_upper.sv */
`timescale 1ns/1ps

module wallace_upper (
  input  booth_pkg::pp_array_t partial_products,
  output booth_pkg::csa_rows_t rows
);
  import booth_pkg::*;

  csa_pair_t [4:0] lvl1;
  csa_pair_t [3:0] lvl2;
  csa_pair_t [1:0] lvl3;
  csa_pair_t [1:0] lvl4;

  // level one, 15 of the 17 partial products in groups of three
  assign lvl1[0] = csa3(partial_products[16], partial_products[15], partial_products[14]);
  assign lvl1[1] = csa3(partial_products[13], partial_products[12], partial_products[11]);
  assign lvl1[2] = csa3(partial_products[10], partial_products[9], partial_products[8]);
  assign lvl1[3] = csa3(partial_products[7], partial_products[6], partial_products[5]);
  assign lvl1[4] = csa3(partial_products[4], partial_products[3], partial_products[2]);

  // level two, pp 1 and pp 0 join here
  assign lvl2[0] = csa3(lvl1[0].sum, lvl1[1].sum, lvl1[2].sum);
  assign lvl2[1] = csa3(lvl1[3].sum, lvl1[4].sum, partial_products[1]);
  assign lvl2[2] = csa3(partial_products[0], lvl1[0].carry, lvl1[1].carry);
  assign lvl2[3] = csa3(lvl1[2].carry, lvl1[3].carry, lvl1[4].carry);

  // level three
  assign lvl3[0] = csa3(lvl2[0].sum, lvl2[1].sum, lvl2[2].sum);
  assign lvl3[1] = csa3(lvl2[3].sum, lvl2[0].carry, lvl2[1].carry);

  // level four
  assign lvl4[0] = csa3(lvl3[0].sum, lvl3[1].sum, lvl2[2].carry);
  assign lvl4[1] = csa3(lvl2[3].carry, lvl3[0].carry, lvl3[1].carry);

  // four rows left, same total modulo 2**65
  assign rows = '{
    sum_a:   lvl4[0].sum,
    sum_b:   lvl4[1].sum,
    carry_a: lvl4[0].carry,
    carry_b: lvl4[1].carry
  };

endmodule

/* wallace_final.sv */
`timescale 1ns/1ps
`include "mul_defines.svh"

module wallace_final (
  input  logic                    clk,
  input  logic                    resetn,
  input  booth_pkg::csa_rows_t    rows,
  output mul_types_pkg::product_t result
);
  import booth_pkg::*;

  csa_rows_t rows_q;
  csa_pair_t lvl5;
  csa_pair_t lvl6;
  row_t      final_sum;

  // second pipeline stage
  always_ff @(posedge clk) begin
    if (!resetn) begin
      rows_q <= '0;
    end else begin
      rows_q <= rows;
    end
  end

  // level five
  assign lvl5 = csa3(rows_q.sum_a, rows_q.sum_b, rows_q.carry_a);

  // level six, down to a single sum and carry
  assign lvl6 = csa3(lvl5.sum, rows_q.carry_b, lvl5.carry);

  // carry-propagate add
  assign final_sum = lvl6.sum + lvl6.carry;
  assign result    = final_sum[2*`MUL_WIDTH-1:0];

  // bit 64 only set by a negative signed product, which still fits in 64 bits
  a_product_fits : assert property (
    @(posedge clk) disable iff (!resetn)
    final_sum[`MUL_ROW_WIDTH-1] |-> final_sum[2*`MUL_WIDTH-1]
  );

endmodule

/* mul_top.sv */
`timescale 1ns/1ps

module mul_top (
  input  logic                     clk,
  input  logic                     resetn,
  input  mul_types_pkg::mul_mode_e mul_signed,
  input  mul_types_pkg::operand_t  ina,
  input  mul_types_pkg::operand_t  inb,
  output mul_types_pkg::product_t  result
);
  import booth_pkg::*;

  pp_array_t partial_products;
  csa_rows_t rows;

  // operand register and recoding
  booth_pp_gen u_pp_gen (
    .clk              (clk),
    .resetn           (resetn),
    .mul_signed       (mul_signed),
    .ina              (ina),
    .inb              (inb),
    .partial_products (partial_products)
  );

  wallace_upper u_upper (
    .partial_products (partial_products),
    .rows             (rows)
  );

  // row register and final add
  wallace_final u_final (
    .clk    (clk),
    .resetn (resetn),
    .rows   (rows),
    .result (result)
  );

endmodule

/* tb_mul.sv */
`timescale 1ns/1ps

module tb_mul;
  import mul_types_pkg::*;

  localparam int CLK_HALF      = 10;
  localparam int RESET_CYCLES  = 10;
  localparam int MODE_PATTERNS = 4;
  localparam int RANDOM_OPS    = 200;
  localparam int MID_OPS       = 5;
  localparam int MID_RESET     = 3;
  localparam int TESTS         = 5;
  localparam int MARGIN        = 20;

  // top bits set in at least one operand, so the two modes differ
  localparam operand_t MODE_A [MODE_PATTERNS] = '{
    32'hf000_000f, 32'hffff_ffff, 32'hdead_beef, 32'h8000_0000
  };
  localparam operand_t MODE_B [MODE_PATTERNS] = '{
    32'h8765_4321, 32'h8000_0001, 32'hcafe_f00d, 32'hffff_ffff
  };

  // one expected result travelling with the pipeline
  typedef struct packed {
    logic     valid;
    product_t value;
  } expect_t;

  // one line of the stimulus file
  typedef struct packed {
    mul_mode_e mode;
    operand_t  a;
    operand_t  b;
    product_t  product;
  } vector_t;

  logic        clk;
  logic        resetn;
  mul_mode_e   mul_signed;
  operand_t    ina;
  operand_t    inb;
  product_t    result;

  expect_t     pending[$];
  vector_t     vectors[$];
  logic [31:0] lcg_state = 32'h491d_1936;
  int          checks = 0;
  int          errors = 0;
  int          error_mark = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100000;

  mul_top dut (
    .clk        (clk),
    .resetn     (resetn),
    .mul_signed (mul_signed),
    .ina        (ina),
    .inb        (inb),
    .result     (result)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the tests did not end within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // full 64-bit multiply of the widened operands
  function automatic product_t expected_product(input mul_mode_e mode, input operand_t a,
                                                input operand_t b);
    logic [63:0] wa;
    logic [63:0] wb;
    if (mode == MODE_SIGNED) begin
      wa = {{32{a[31]}}, a};
      wb = {{32{b[31]}}, b};
    end else begin
      wa = {32'b0, a};
      wb = {32'b0, b};
    end
    return wa * wb;
  endfunction

  task automatic check_product(input product_t got, input product_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t ns: result = %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          code;
    string       line;
    logic [31:0] mode_raw;
    logic [31:0] a_raw;
    logic [31:0] b_raw;
    logic [63:0] p_raw;
    fd = $fopen("mul_stimulus.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open mul_stimulus.txt, no directed vectors run");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          code = $sscanf(line, "%h %h %h %h", mode_raw, a_raw, b_raw, p_raw);
          if (code == 4) begin
            vectors.push_back('{mode: mul_mode_e'(mode_raw[0]), a: a_raw, b: b_raw,
                                product: p_raw});
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one clock: check the result launched two edges back, then drive
  task automatic run_cycle(input logic rst, input logic valid, input mul_mode_e mode,
                           input operand_t a, input operand_t b, input product_t exp);
    expect_t ent;
    @(negedge clk);
    ent = pending.pop_front();
    if (ent.valid) begin
      check_product(result, ent.value);
    end
    // the op still in flight is flushed by this reset edge
    if (rst) begin
      pending[0] = '{valid: 1'b1, value: '0};
    end
    resetn     = !rst;
    mul_signed = mode;
    ina        = a;
    inb        = b;
    if (rst) begin
      pending.push_back('{valid: 1'b1, value: '0});
    end else begin
      pending.push_back('{valid: valid, value: exp});
    end
  endtask

  task automatic end_test(input string name);
    repeat (2) run_cycle(1'b0, 1'b0, MODE_UNSIGNED, '0, '0, '0);
    if (errors == error_mark) begin
      tests_ok++;
      $display("test %s: ok", name);
    end else begin
      tests_bad++;
      $display("test %s: FAILED with %0d errors", name, errors - error_mark);
    end
    error_mark = errors;
  endtask

  initial begin
    logic [31:0] r;
    operand_t    a;
    operand_t    b;
    mul_mode_e   mode;

    resetn     = 1'b0;
    mul_signed = MODE_UNSIGNED;
    ina        = '0;
    inb        = '0;
    pending.push_back('0);
    pending.push_back('0);
    load_vectors();
    cycle_limit = RESET_CYCLES + vectors.size() + 2 * MODE_PATTERNS + RANDOM_OPS
                + MID_OPS + MID_RESET + 1 + 2 * TESTS + MARGIN;

    repeat (RESET_CYCLES) run_cycle(1'b1, 1'b0, MODE_UNSIGNED, '0, '0, '0);
    end_test("reset");

    foreach (vectors[i]) begin
      if (vectors[i].product !== expected_product(vectors[i].mode, vectors[i].a,
                                                  vectors[i].b)) begin
        errors++;
        $display("stimulus vector %0d states a product that is not a*b", i);
      end
      run_cycle(1'b0, 1'b1, vectors[i].mode, vectors[i].a, vectors[i].b,
                vectors[i].product);
    end
    end_test("file_vectors");

    for (int i = 0; i < MODE_PATTERNS; i++) begin
      run_cycle(1'b0, 1'b1, MODE_UNSIGNED, MODE_A[i], MODE_B[i],
                expected_product(MODE_UNSIGNED, MODE_A[i], MODE_B[i]));
      run_cycle(1'b0, 1'b1, MODE_SIGNED, MODE_A[i], MODE_B[i],
                expected_product(MODE_SIGNED, MODE_A[i], MODE_B[i]));
    end
    end_test("mode");

    repeat (RANDOM_OPS) begin
      r    = lcg_next();
      mode = mul_mode_e'(r[31]);
      a    = lcg_next();
      b    = lcg_next();
      run_cycle(1'b0, 1'b1, mode, a, b, expected_product(mode, a, b));
    end
    end_test("random_pipelined");

    repeat (MID_OPS) begin
      r    = lcg_next();
      mode = mul_mode_e'(r[31]);
      a    = lcg_next();
      b    = lcg_next();
      run_cycle(1'b0, 1'b1, mode, a, b, expected_product(mode, a, b));
    end
    // operands keep changing under reset and must not leak out
    repeat (MID_RESET) begin
      a = lcg_next();
      b = lcg_next();
      run_cycle(1'b1, 1'b0, MODE_SIGNED, a, b, '0);
    end
    run_cycle(1'b0, 1'b1, MODE_SIGNED, 32'h8000_0001, 32'h7fff_ffff,
              expected_product(MODE_SIGNED, 32'h8000_0001, 32'h7fff_ffff));
    end_test("reset_mid_stream");

    $display("tests: %0d ok, %0d bad; checks: %0d, errors: %0d",
             tests_ok, tests_bad, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* mul_stimulus.txt */
# columns: mode (0 unsigned, 1 signed), a, b, expected 64-bit product, all hex
# one multiply per line, applied back to back
0 00000000 00000000 0000000000000000
1 00000000 00000000 0000000000000000
0 00000001 00000001 0000000000000001
1 00000001 00000001 0000000000000001
0 00000000 ffffffff 0000000000000000
1 ffffffff 00000000 0000000000000000
0 00000001 ffffffff 00000000ffffffff
1 00000001 ffffffff ffffffffffffffff
0 ffffffff 00000001 00000000ffffffff
1 ffffffff 00000001 ffffffffffffffff
0 ffffffff ffffffff fffffffe00000001
1 ffffffff ffffffff 0000000000000001
1 80000000 80000000 4000000000000000
0 80000000 80000000 4000000000000000
1 80000000 ffffffff 0000000080000000
0 80000000 ffffffff 7fffffff80000000
1 ffffffff 80000000 0000000080000000
1 7fffffff 7fffffff 3fffffff00000001
1 7fffffff 80000000 c000000080000000
1 80000000 00000001 ffffffff80000000
0 80000000 00000001 0000000080000000
0 aaaaaaaa 55555555 38e38e3871c71c72
1 aaaaaaaa 55555555 e38e38e371c71c72
0 55555555 55555555 1c71c71c38e38e39
1 55555555 55555555 1c71c71c38e38e39
1 aaaaaaaa aaaaaaaa 1c71c71ce38e38e4
0 aaaaaaaa aaaaaaaa 71c71c70e38e38e4
0 12345678 00000010 0000000123456780
1 fffffffe 00000003 fffffffffffffffa
0 fffffffe 00000003 00000002fffffffa

/* tb.f */
+incdir+.
mul_types_pkg.sv
booth_pkg.sv
booth_pp_gen.sv
wallace_upper.sv
wallace_final.sv
mul_top.sv
tb_mul.sv

/* run.sh */
#!/bin/sh
# build and run the multiplier testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module tb_mul -o sim_tb_mul
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_tb_mul)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1
